/* include/uop_params.svh */
`ifndef UOP_PARAMS_SVH
`define UOP_PARAMS_SVH

////////////////////
// Opcode and ROM sizing
////////////////////

// One byte per opcode
`define OPCODE_WIDTH 8

// Micro-op ROM address and number of entries in use
`define ROM_ADDR_WIDTH 6
`define ROM_DEPTH 37

////////////////////
// Modelled program counter
////////////////////

`define PC_WIDTH 16
`define PC_RESET_VALUE 16'h0100

////////////////////
// Buffer depths
////////////////////

`define OPCODE_FIFO_DEPTH 4
`define UOP_FIFO_DEPTH 8

`endif

/* logic/uopPkg.sv */
`include "uop_params.svh"

package uopPkg;

	////////////////////
	// Micro-op fields
	////////////////////

	// Flow control, decides how the sequencer and the counter move
	typedef enum logic [2:0]
	{
		fcOp       = 3'd0,
		fcInc      = 3'd1,
		fcEof      = 3'd2,
		fcIncEof   = 3'd3,
		fcUpdFlags = 3'd4
	} flowCtlT;

	// What the datapath does with the operand
	typedef enum logic [5:0]
	{
		acNop     = 6'd0,
		acSma     = 6'd1,
		acSmw     = 6'd2,
		acSrm     = 6'd3,
		acSx16r   = 6'd4,
		acSrx16   = 6'd5,
		acInc16   = 6'd6,
		acDec16   = 6'd7,
		acAddx16  = 6'd8,
		acAddx16u = 6'd9,
		acSubx16  = 6'd10,
		acSpc     = 6'd11,
		acZ801bop = 6'd12
	} actionT;

	// Register or scratch selector
	typedef enum logic [5:0]
	{
		selNull = 6'd0,
		selA    = 6'd1,
		selB    = 6'd2,
		selC    = 6'd3,
		selPc   = 6'd4,
		selSp   = 6'd5,
		selX8   = 6'd6,
		selX16  = 6'd7
	} operandT;

	// 15-bit ROM word, flow in the top bits
	typedef struct packed
	{
		flowCtlT flow;
		actionT  action;
		operandT operand;
	} uopT;

	typedef logic [`ROM_ADDR_WIDTH-1:0] romAddrT;

endpackage

/* logic/uopFlowLut.sv */
`timescale 1ns/100ps
`include "uop_params.svh"

module uopFlowLut
(
	input  logic [`OPCODE_WIDTH-1:0] opcode,
	output uopPkg::romAddrT          flowStart
);

	////////////////////
	// Opcode to flow start
	////////////////////

	always_comb
	begin
		case (opcode)
			// NOP
			8'h00: flowStart = uopPkg::romAddrT'(2);
			// LD B,n and LD C,n
			8'h06: flowStart = uopPkg::romAddrT'(3);
			8'h0E: flowStart = uopPkg::romAddrT'(6);
			// INC B and DEC B
			8'h04: flowStart = uopPkg::romAddrT'(9);
			8'h05: flowStart = uopPkg::romAddrT'(11);
			// ALU ops against B
			8'h80: flowStart = uopPkg::romAddrT'(13);
			8'h90: flowStart = uopPkg::romAddrT'(16);
			// Relative jump, always taken
			8'h18: flowStart = uopPkg::romAddrT'(19);
			// Stack pair ops
			8'hC5: flowStart = uopPkg::romAddrT'(25);
			8'hC1: flowStart = uopPkg::romAddrT'(31);
			// Anything else runs the generic one-byte flow
			default:
			begin
				flowStart = uopPkg::romAddrT'(0);
			end
		endcase
	end

endmodule

/* logic/uopRom.sv */
`timescale 1ns/100ps

module uopRom
(
	input  uopPkg::romAddrT addr,
	output uopPkg::uopT     uop
);

	always_comb
	begin
		case (addr)
			////////////////////
			// Default one-byte op
			0:  uop = '{uopPkg::fcUpdFlags, uopPkg::acZ801bop, uopPkg::selA};
			1:  uop = '{uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull};

			////////////////////
			// NOP
			2:  uop = '{uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull};

			////////////////////
			// LD B,n
			3:  uop = '{uopPkg::fcInc, uopPkg::acSma, uopPkg::selPc};
			4:  uop = '{uopPkg::fcInc, uopPkg::acNop, uopPkg::selNull};
			5:  uop = '{uopPkg::fcEof, uopPkg::acSrm, uopPkg::selB};

			////////////////////
			// LD C,n
			6:  uop = '{uopPkg::fcInc, uopPkg::acSma, uopPkg::selPc};
			7:  uop = '{uopPkg::fcInc, uopPkg::acNop, uopPkg::selNull};
			8:  uop = '{uopPkg::fcEof, uopPkg::acSrm, uopPkg::selC};

			////////////////////
			// INC B
			9:  uop = '{uopPkg::fcUpdFlags, uopPkg::acInc16, uopPkg::selB};
			10: uop = '{uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull};

			////////////////////
			// DEC B
			11: uop = '{uopPkg::fcUpdFlags, uopPkg::acDec16, uopPkg::selB};
			12: uop = '{uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull};

			////////////////////
			// ADD A,B goes through x16
			13: uop = '{uopPkg::fcOp, uopPkg::acSx16r, uopPkg::selA};
			14: uop = '{uopPkg::fcUpdFlags, uopPkg::acAddx16u, uopPkg::selB};
			15: uop = '{uopPkg::fcIncEof, uopPkg::acSrx16, uopPkg::selA};

			////////////////////
			// SUB B
			16: uop = '{uopPkg::fcOp, uopPkg::acSx16r, uopPkg::selA};
			17: uop = '{uopPkg::fcUpdFlags, uopPkg::acSubx16, uopPkg::selB};
			18: uop = '{uopPkg::fcIncEof, uopPkg::acSrx16, uopPkg::selA};

			////////////////////
			// JR n
			19: uop = '{uopPkg::fcInc, uopPkg::acSma, uopPkg::selPc};
			// Memory needs a cycle before the read
			20: uop = '{uopPkg::fcOp, uopPkg::acNop, uopPkg::selNull};
			21: uop = '{uopPkg::fcInc, uopPkg::acSrm, uopPkg::selX8};
			22: uop = '{uopPkg::fcOp, uopPkg::acSx16r, uopPkg::selPc};
			// Sign-extended offset added to pc
			23: uop = '{uopPkg::fcOp, uopPkg::acAddx16, uopPkg::selX8};
			24: uop = '{uopPkg::fcEof, uopPkg::acSpc, uopPkg::selX16};

			////////////////////
			// PUSH BC, high byte first
			25: uop = '{uopPkg::fcOp, uopPkg::acDec16, uopPkg::selSp};
			26: uop = '{uopPkg::fcOp, uopPkg::acSma, uopPkg::selSp};
			27: uop = '{uopPkg::fcOp, uopPkg::acSmw, uopPkg::selB};
			28: uop = '{uopPkg::fcOp, uopPkg::acDec16, uopPkg::selSp};
			29: uop = '{uopPkg::fcOp, uopPkg::acSmw, uopPkg::selC};
			30: uop = '{uopPkg::fcIncEof, uopPkg::acSma, uopPkg::selPc};

			////////////////////
			// POP BC
			31: uop = '{uopPkg::fcOp, uopPkg::acSma, uopPkg::selSp};
			32: uop = '{uopPkg::fcOp, uopPkg::acInc16, uopPkg::selSp};
			33: uop = '{uopPkg::fcOp, uopPkg::acSrm, uopPkg::selC};
			34: uop = '{uopPkg::fcOp, uopPkg::acSrm, uopPkg::selB};
			35: uop = '{uopPkg::fcInc, uopPkg::acInc16, uopPkg::selSp};
			36: uop = '{uopPkg::fcEof, uopPkg::acSma, uopPkg::selPc};

			// Unused entries are harmless bubbles
			default:
			begin
				uop = '{uopPkg::fcOp, uopPkg::acNop, uopPkg::selNull};
			end
		endcase
	end

endmodule

/* logic/uopFifo.sv */
`timescale 1ns/100ps

module uopFifo
#(
	parameter type payloadT = logic [7:0],
	parameter int  depth    = 4
)
(
	input  logic    clk,
	input  logic    rst,
	input  logic    inValid,
	output logic    inReady,
	input  payloadT inData,
	output logic    outValid,
	input  logic    outReady,
	output payloadT outData
);

	localparam int ptrWidth   = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);

	payloadT mem [depth];
	logic [ptrWidth-1:0]   wrPtr;
	logic [ptrWidth-1:0]   rdPtr;
	logic [countWidth-1:0] count;
	logic                  push;
	logic                  pop;

	assign inReady  = (count != countWidth'(depth));
	assign outValid = (count != '0);
	assign outData  = mem[rdPtr];
	assign push     = inValid && inReady;
	assign pop      = outValid && outReady;

	// Storage
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= inData;
	end

	////////////////////
	// Pointers and occupancy
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Occupancy never passes the depth
	assert property (@(posedge clk) disable iff (rst)
		count <= countWidth'(depth));

	// Pointers meet only when the buffer is empty or full
	assert property (@(posedge clk) disable iff (rst)
		(wrPtr == rdPtr) == ((count == '0) || (count == countWidth'(depth))));

endmodule

/* logic/uopSequencer.sv */
`timescale 1ns/100ps
`include "uop_params.svh"

module uopSequencer
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     inValid,
	output logic                     inReady,
	input  logic [`OPCODE_WIDTH-1:0] inData,
	output logic                     outValid,
	input  logic                     outReady,
	output uopPkg::uopT              outData
);

	logic            busy;
	uopPkg::romAddrT upc;
	uopPkg::romAddrT flowStart;
	uopPkg::uopT     romWord;
	logic            accept;
	logic            step;
	logic            flowDone;

	////////////////////
	// Lookup and ROM
	////////////////////

	uopFlowLut flowLut
	(
		.opcode    (inData),
		.flowStart (flowStart)
	);

	uopRom rom
	(
		.addr (upc),
		.uop  (romWord)
	);

	// Opcodes only taken between flows
	assign inReady  = !busy;
	assign accept   = inValid && inReady;
	assign outValid = busy;
	assign outData  = romWord;
	assign step     = outValid && outReady;

	assign flowDone = (romWord.flow == uopPkg::fcEof) ||
		(romWord.flow == uopPkg::fcIncEof);

	////////////////////
	// Micro-program counter
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			upc  <= '0;
		end
		else if (accept)
		begin
			busy <= 1'b1;
			upc  <= flowStart;
		end
		else if (step)
		begin
			if (flowDone)
				busy <= 1'b0;
			else
				upc <= upc + 1'b1;
		end
	end

	// Never walks past the last flow
	assert property (@(posedge clk) disable iff (rst)
		busy |-> (upc < `ROM_DEPTH));

endmodule

/* logic/uopIssue.sv */
`timescale 1ns/100ps
`include "uop_params.svh"

module uopIssue
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inValid,
	output logic                  inReady,
	input  uopPkg::uopT           inData,
	output logic                  uopValid,
	input  logic                  uopReady,
	output uopPkg::flowCtlT       uopFlow,
	output uopPkg::actionT        uopAction,
	output uopPkg::operandT       uopOperand,
	output logic [`PC_WIDTH-1:0]  uopPc,
	output logic                  uopLast
);

	logic [`PC_WIDTH-1:0] pc;
	logic                 fire;
	logic                 pcStep;

	// Straight through with the consumer setting the pace
	assign uopValid   = inValid;
	assign inReady    = uopReady;
	assign uopFlow    = inData.flow;
	assign uopAction  = inData.action;
	assign uopOperand = inData.operand;
	assign uopLast    = (inData.flow == uopPkg::fcEof) || (inData.flow == uopPkg::fcIncEof);

	// Counter value before this micro-op
	assign uopPc = pc;

	assign fire   = uopValid && uopReady;
	assign pcStep = (inData.flow == uopPkg::fcInc) || (inData.flow == uopPkg::fcIncEof);

	////////////////////
	// Modelled program counter
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= `PC_RESET_VALUE;
		else if (fire && pcStep)
			pc <= pc + 1'b1;
	end

	// A stalled micro-op from the buffer is held until it is taken
	assert property (@(posedge clk) disable iff (rst)
		(inValid && !inReady) |=> (inValid && $stable(inData)));

endmodule

/* logic/uopEngine.sv */
`timescale 1ns/100ps
`include "uop_params.svh"

module uopEngine
(
	input  logic                     clk,
	input  logic                     rst,
	// Opcode input
	input  logic                     opValid,
	output logic                     opReady,
	input  logic [`OPCODE_WIDTH-1:0] opcode,
	// Micro-op output
	output logic                     uopValid,
	input  logic                     uopReady,
	output uopPkg::flowCtlT          uopFlow,
	output uopPkg::actionT           uopAction,
	output uopPkg::operandT          uopOperand,
	output logic [`PC_WIDTH-1:0]     uopPc,
	output logic                     uopLast
);

	logic                     seqOpValid;
	logic                     seqOpReady;
	logic [`OPCODE_WIDTH-1:0] seqOpcode;
	logic                     seqUopValid;
	logic                     seqUopReady;
	uopPkg::uopT              seqUop;
	logic                     issValid;
	logic                     issReady;
	uopPkg::uopT              issUop;

	////////////////////
	// Opcode buffer
	////////////////////

	uopFifo
	#(
		.payloadT (logic [`OPCODE_WIDTH-1:0]),
		.depth    (`OPCODE_FIFO_DEPTH)
	) opFifo
	(
		.clk      (clk),
		.rst      (rst),
		.inValid  (opValid),
		.inReady  (opReady),
		.inData   (opcode),
		.outValid (seqOpValid),
		.outReady (seqOpReady),
		.outData  (seqOpcode)
	);

	uopSequencer sequencer
	(
		.clk      (clk),
		.rst      (rst),
		.inValid  (seqOpValid),
		.inReady  (seqOpReady),
		.inData   (seqOpcode),
		.outValid (seqUopValid),
		.outReady (seqUopReady),
		.outData  (seqUop)
	);

	////////////////////
	// Micro-op buffer and issue
	////////////////////

	uopFifo
	#(
		.payloadT (uopPkg::uopT),
		.depth    (`UOP_FIFO_DEPTH)
	) uopQueue
	(
		.clk      (clk),
		.rst      (rst),
		.inValid  (seqUopValid),
		.inReady  (seqUopReady),
		.inData   (seqUop),
		.outValid (issValid),
		.outReady (issReady),
		.outData  (issUop)
	);

	uopIssue issue
	(
		.clk        (clk),
		.rst        (rst),
		.inValid    (issValid),
		.inReady    (issReady),
		.inData     (issUop),
		.uopValid   (uopValid),
		.uopReady   (uopReady),
		.uopFlow    (uopFlow),
		.uopAction  (uopAction),
		.uopOperand (uopOperand),
		.uopPc      (uopPc),
		.uopLast    (uopLast)
	);

endmodule

/* testbench/uopChecker.sv */
`timescale 1ns/100ps
`include "uop_params.svh"

module uopChecker
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     opValid,
	input  logic                     opReady,
	input  logic [`OPCODE_WIDTH-1:0] opcode,
	input  logic                     uopValid,
	input  logic                     uopReady,
	input  uopPkg::flowCtlT          uopFlow,
	input  uopPkg::actionT           uopAction,
	input  uopPkg::operandT          uopOperand,
	input  logic [`PC_WIDTH-1:0]     uopPc,
	input  logic                     uopLast,
	input  logic                     idleCheck,
	input  logic                     fullCheck,
	output int                       errors,
	output int                       checked,
	output int                       pending
);

	uopPkg::uopT          expQ [$];
	uopPkg::uopT          want;
	uopPkg::uopT          next;
	logic [`PC_WIDTH-1:0] refPc;
	int                   idx;

	function automatic uopPkg::uopT makeUop(input uopPkg::flowCtlT f, input uopPkg::actionT a,
		input uopPkg::operandT o);
		return '{f, a, o};
	endfunction

	function automatic logic endsFlow(input uopPkg::flowCtlT f);
		return (f == uopPkg::fcEof) || (f == uopPkg::fcIncEof);
	endfunction

	function automatic logic stepsPc(input uopPkg::flowCtlT f);
		return (f == uopPkg::fcInc) || (f == uopPkg::fcIncEof);
	endfunction

	////////////////////
	// Reference flows, step idx of the flow for op
	////////////////////

	function automatic uopPkg::uopT expectedStep(input logic [`OPCODE_WIDTH-1:0] op, input int idx);
		uopPkg::uopT s;
		case ({op, idx[2:0]})
			{8'h00, 3'd0}: s = makeUop(uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull);
			// Loads fetch the immediate byte
			{8'h06, 3'd0}: s = makeUop(uopPkg::fcInc, uopPkg::acSma, uopPkg::selPc);
			{8'h06, 3'd1}: s = makeUop(uopPkg::fcInc, uopPkg::acNop, uopPkg::selNull);
			{8'h06, 3'd2}: s = makeUop(uopPkg::fcEof, uopPkg::acSrm, uopPkg::selB);
			{8'h0E, 3'd0}: s = makeUop(uopPkg::fcInc, uopPkg::acSma, uopPkg::selPc);
			{8'h0E, 3'd1}: s = makeUop(uopPkg::fcInc, uopPkg::acNop, uopPkg::selNull);
			{8'h0E, 3'd2}: s = makeUop(uopPkg::fcEof, uopPkg::acSrm, uopPkg::selC);
			{8'h04, 3'd0}: s = makeUop(uopPkg::fcUpdFlags, uopPkg::acInc16, uopPkg::selB);
			{8'h04, 3'd1}: s = makeUop(uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull);
			{8'h05, 3'd0}: s = makeUop(uopPkg::fcUpdFlags, uopPkg::acDec16, uopPkg::selB);
			{8'h05, 3'd1}: s = makeUop(uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull);
			{8'h80, 3'd0}: s = makeUop(uopPkg::fcOp, uopPkg::acSx16r, uopPkg::selA);
			{8'h80, 3'd1}: s = makeUop(uopPkg::fcUpdFlags, uopPkg::acAddx16u, uopPkg::selB);
			{8'h80, 3'd2}: s = makeUop(uopPkg::fcIncEof, uopPkg::acSrx16, uopPkg::selA);
			{8'h90, 3'd0}: s = makeUop(uopPkg::fcOp, uopPkg::acSx16r, uopPkg::selA);
			{8'h90, 3'd1}: s = makeUop(uopPkg::fcUpdFlags, uopPkg::acSubx16, uopPkg::selB);
			{8'h90, 3'd2}: s = makeUop(uopPkg::fcIncEof, uopPkg::acSrx16, uopPkg::selA);
			// JR n, pc moves twice before the offset is added
			{8'h18, 3'd0}: s = makeUop(uopPkg::fcInc, uopPkg::acSma, uopPkg::selPc);
			{8'h18, 3'd1}: s = makeUop(uopPkg::fcOp, uopPkg::acNop, uopPkg::selNull);
			{8'h18, 3'd2}: s = makeUop(uopPkg::fcInc, uopPkg::acSrm, uopPkg::selX8);
			{8'h18, 3'd3}: s = makeUop(uopPkg::fcOp, uopPkg::acSx16r, uopPkg::selPc);
			{8'h18, 3'd4}: s = makeUop(uopPkg::fcOp, uopPkg::acAddx16, uopPkg::selX8);
			{8'h18, 3'd5}: s = makeUop(uopPkg::fcEof, uopPkg::acSpc, uopPkg::selX16);
			{8'hC5, 3'd0}: s = makeUop(uopPkg::fcOp, uopPkg::acDec16, uopPkg::selSp);
			{8'hC5, 3'd1}: s = makeUop(uopPkg::fcOp, uopPkg::acSma, uopPkg::selSp);
			{8'hC5, 3'd2}: s = makeUop(uopPkg::fcOp, uopPkg::acSmw, uopPkg::selB);
			{8'hC5, 3'd3}: s = makeUop(uopPkg::fcOp, uopPkg::acDec16, uopPkg::selSp);
			{8'hC5, 3'd4}: s = makeUop(uopPkg::fcOp, uopPkg::acSmw, uopPkg::selC);
			{8'hC5, 3'd5}: s = makeUop(uopPkg::fcIncEof, uopPkg::acSma, uopPkg::selPc);
			{8'hC1, 3'd0}: s = makeUop(uopPkg::fcOp, uopPkg::acSma, uopPkg::selSp);
			{8'hC1, 3'd1}: s = makeUop(uopPkg::fcOp, uopPkg::acInc16, uopPkg::selSp);
			{8'hC1, 3'd2}: s = makeUop(uopPkg::fcOp, uopPkg::acSrm, uopPkg::selC);
			{8'hC1, 3'd3}: s = makeUop(uopPkg::fcOp, uopPkg::acSrm, uopPkg::selB);
			{8'hC1, 3'd4}: s = makeUop(uopPkg::fcInc, uopPkg::acInc16, uopPkg::selSp);
			{8'hC1, 3'd5}: s = makeUop(uopPkg::fcEof, uopPkg::acSma, uopPkg::selPc);
			// Unknown opcodes, generic one-byte op
			default:
			begin
				if (idx == 0)
					s = makeUop(uopPkg::fcUpdFlags, uopPkg::acZ801bop, uopPkg::selA);
				else
					s = makeUop(uopPkg::fcIncEof, uopPkg::acNop, uopPkg::selNull);
			end
		endcase
		return s;
	endfunction

	task automatic compareField(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	////////////////////
	// Comparing process
	////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			expQ.delete();
			refPc   = `PC_RESET_VALUE;
			errors  = 0;
			checked = 0;
		end
		else
		begin
			if (idleCheck && (!opReady || uopValid))
			begin
				$display("engine not idle after reset at %0t ns: opReady %b, uopValid %b",
					$time, opReady, uopValid);
				errors++;
			end
			if (fullCheck && opReady)
			begin
				$display("opReady still high at %0t ns after the output stalled", $time);
				errors++;
			end
			if (uopValid && expQ.size() == 0)
			begin
				$display("micro-op offered at %0t ns with no opcode outstanding", $time);
				errors++;
			end
			else if (uopValid && uopReady)
			begin
				want = expQ.pop_front();
				checked++;
				compareField("uopFlow", int'(uopFlow), int'(want.flow));
				compareField("uopAction", int'(uopAction), int'(want.action));
				compareField("uopOperand", int'(uopOperand), int'(want.operand));
				compareField("uopPc", int'(uopPc), int'(refPc));
				compareField("uopLast", int'(uopLast), int'(endsFlow(want.flow)));
				if (stepsPc(want.flow))
					refPc = refPc + 1'b1;
			end
			// Whole flow queued when the opcode is taken
			if (opValid && opReady)
			begin
				idx = 0;
				do
				begin
					next = expectedStep(opcode, idx);
					expQ.push_back(next);
					idx++;
				end
				while (!endsFlow(next.flow) && idx < 8);
			end
		end
		pending = expQ.size();
	end

endmodule

/* testbench/tbUopEngine.sv */
`timescale 1ns/100ps
`include "uop_params.svh"

module tbUopEngine;

	localparam int clkPeriod = 8;
	localparam int randomOps = 200;
	localparam int stallOps  = 12;
	// Opcodes sent over all tests set the watchdog limit
	localparam int totalOps    = 10 + 1 + 3 + randomOps + stallOps;
	localparam int limitCycles = 40 * totalOps + 200;

	logic                     clk;
	logic                     rst;
	logic                     opValid;
	logic                     opReady;
	logic [`OPCODE_WIDTH-1:0] opcode;
	logic                     uopValid;
	logic                     uopReady;
	uopPkg::flowCtlT          uopFlow;
	uopPkg::actionT           uopAction;
	uopPkg::operandT          uopOperand;
	logic [`PC_WIDTH-1:0]     uopPc;
	logic                     uopLast;
	logic                     idleCheck;
	logic                     fullCheck;
	int                       errors;
	int                       checked;
	int                       pending;
	int                       seed;
	int                       readyMode;
	int                       testCount;
	int                       lastErrors;
	logic [31:0]              rnd;
	logic [`OPCODE_WIDTH-1:0] keptOps [10];
	logic [`OPCODE_WIDTH-1:0] randOps [randomOps];

	uopEngine dut
	(
		.clk        (clk),
		.rst        (rst),
		.opValid    (opValid),
		.opReady    (opReady),
		.opcode     (opcode),
		.uopValid   (uopValid),
		.uopReady   (uopReady),
		.uopFlow    (uopFlow),
		.uopAction  (uopAction),
		.uopOperand (uopOperand),
		.uopPc      (uopPc),
		.uopLast    (uopLast)
	);

	uopChecker check
	(
		.clk        (clk),
		.rst        (rst),
		.opValid    (opValid),
		.opReady    (opReady),
		.opcode     (opcode),
		.uopValid   (uopValid),
		.uopReady   (uopReady),
		.uopFlow    (uopFlow),
		.uopAction  (uopAction),
		.uopOperand (uopOperand),
		.uopPc      (uopPc),
		.uopLast    (uopLast),
		.idleCheck  (idleCheck),
		.fullCheck  (fullCheck),
		.errors     (errors),
		.checked    (checked),
		.pending    (pending)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////
	// Output back-pressure
	////////////////////

	// Mode 0 always ready, mode 1 random, mode 2 stalled
	always @(posedge clk)
	begin
		#1;
		case (readyMode)
			0: uopReady = 1'b1;
			1:
			begin
				rnd      = $random(seed);
				uopReady = rnd[0];
			end
			default: uopReady = 1'b0;
		endcase
	end

	// Called 1 ns after an edge and returns 1 ns after the transfer edge
	task automatic sendOpcode(input logic [`OPCODE_WIDTH-1:0] op);
		logic taken;
		opValid = 1'b1;
		opcode  = op;
		taken   = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = opReady;
			@(posedge clk);
			#1;
		end
		opValid = 1'b0;
	endtask

	task automatic waitDrain();
		do
			@(negedge clk);
		while (pending != 0);
		repeat (3) @(posedge clk);
		#1;
	endtask

	task automatic finishTest(input string name);
		waitDrain();
		testCount++;
		$display("test %0d (%s) done: %0d micro-ops checked so far, %0d new errors",
			testCount, name, checked, errors - lastErrors);
		lastErrors = errors;
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		seed       = 58;
		rst        = 1'b1;
		opValid    = 1'b0;
		opcode     = '0;
		uopReady   = 1'b1;
		readyMode  = 0;
		idleCheck  = 1'b0;
		fullCheck  = 1'b0;
		testCount  = 0;
		lastErrors = 0;
		keptOps    = '{8'h00, 8'h06, 8'h0E, 8'h04, 8'h05, 8'h80, 8'h90, 8'h18, 8'hC5, 8'hC1};
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		idleCheck = 1'b1;
		repeat (20) @(posedge clk);
		#1;
		idleCheck = 1'b0;
		finishTest("idle after reset");

		foreach (keptOps[i])
		begin
			sendOpcode(keptOps[i]);
			waitDrain();
		end
		finishTest("single kept opcodes");

		sendOpcode(8'h3F);
		finishTest("unknown opcode");

		// NOP, LD B,n and JR n move the counter by 1, 2 and 2
		sendOpcode(8'h00);
		sendOpcode(8'h06);
		sendOpcode(8'h18);
		finishTest("counter across mixed flows");

		// Draw the stream first so the ready process owns the seed afterwards
		for (int i = 0; i < randomOps; i++)
		begin
			rnd = $random(seed);
			if (rnd[3:0] < 4'd10)
				randOps[i] = keptOps[rnd[3:0]];
			else
				randOps[i] = rnd[15:8];
		end
		readyMode = 1;
		for (int i = 0; i < randomOps; i++)
			sendOpcode(randOps[i]);
		finishTest("random back-pressure");

		readyMode = 2;
		fork
			begin
				repeat (49) @(posedge clk);
				#1;
				fullCheck = 1'b1;
				@(posedge clk);
				#1;
				fullCheck = 1'b0;
				readyMode = 0;
			end
			begin
				// Long flows only so both FIFOs fill quickly
				for (int i = 0; i < stallOps; i++)
					sendOpcode(keptOps[6 + (i % 4)]);
			end
		join
		finishTest("output stall");

		$display("summary: %0d tests, %0d micro-ops checked, %0d errors, %0d pending",
			testCount, checked, errors, pending);
		if (errors == 0 && pending == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(limitCycles * clkPeriod);
		$display("timeout: the run did not finish within %0d cycles", limitCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* tb.f */
+incdir+include
logic/uopPkg.sv
logic/uopFlowLut.sv
logic/uopRom.sv
logic/uopFifo.sv
logic/uopSequencer.sv
logic/uopIssue.sv
logic/uopEngine.sv
testbench/uopChecker.sv
testbench/tbUopEngine.sv

/* Makefile */
# Verilator simulation of the micro-op engine testbench

VERILATOR ?= verilator
TOP       ?= tbUopEngine
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
